//--- source/fetch_pkg.sv
package fetch_pkg;

    // address and data width
    localparam int addr_w = 32;

    // low bits dropped for word alignment
    localparam int byte_off_w = 2;

    // fetch unit to cache
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic              epoch;
    } fetch_req_t;

    // cache to fetch unit, pc and epoch echoed from the request
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic              epoch;
        logic [addr_w-1:0] instr;
    } fetch_rsp_t;

    // output stream of the subsystem
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] instr;
    } fetch_bundle_t;

    // refill request, word aligned byte address
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } mem_req_t;

    // cache lookup FSM
    typedef enum logic [1:0] {
        idle        = 2'd0,
        compare     = 2'd1,
        refill_req  = 2'd2,
        refill_wait = 2'd3
    } cache_state_t;

endpackage

//--- source/stream_skid.sv
`timescale 1ns/1ps

module stream_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     main_valid;
    logic     skid_valid;
    payload_t main_data;
    payload_t skid_data;
    logic     push;
    logic     main_free;

    // ready only depends on local state, not on out_ready
    assign in_ready  = !skid_valid;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    assign push      = in_valid && in_ready;
    assign main_free = !main_valid || out_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_free)
        begin
            // skid entry drains first to keep order
            if (skid_valid)
            begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end
            else
            begin
                main_valid <= push;
            end
        end
        else if (push)
        begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            if (skid_valid)
                main_data <= skid_data;
            else if (push)
                main_data <= in_data;
        end
        else if (push)
        begin
            skid_data <= in_data;
        end
    end

endmodule

//--- source/i_cache.sv
`timescale 1ns/1ps

module i_cache #(
    parameter int LINES = 16
) (
    input  logic                           clk,
    input  logic                           rst,

    // lookup side
    input  logic                           req_valid,
    output logic                           req_ready,
    input  fetch_pkg::fetch_req_t          req,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output fetch_pkg::fetch_rsp_t          rsp,

    // refill side
    output logic                           mem_req_valid,
    input  logic                           mem_req_ready,
    output fetch_pkg::mem_req_t            mem_req,
    input  logic                           mem_rsp_valid,
    output logic                           mem_rsp_ready,
    input  logic [fetch_pkg::addr_w-1:0]   mem_rsp_data
);

    import fetch_pkg::*;

    localparam int index_w = $clog2(LINES);
    localparam int tag_w   = addr_w - index_w - byte_off_w;

    // line storage
    logic [LINES-1:0]   line_valid;
    logic [tag_w-1:0]   tag_mem  [LINES];
    logic [addr_w-1:0]  data_mem [LINES];

    cache_state_t       state_q;
    cache_state_t       state_d;
    fetch_req_t         req_q;

    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tag;
    logic               hit;
    logic               accept;
    logic               refill_done;

    assign idx = req_q.pc[byte_off_w +: index_w];
    assign tag = req_q.pc[addr_w-1 -: tag_w];

    assign hit = line_valid[idx] && (tag_mem[idx] == tag);

    assign req_ready     = (state_q == idle);
    assign accept        = req_valid && req_ready;
    assign rsp_valid     = (state_q == compare) && hit;
    assign mem_req_valid = (state_q == refill_req);
    assign mem_rsp_ready = (state_q == refill_wait);
    assign refill_done   = mem_rsp_ready && mem_rsp_valid;

    assign rsp.pc    = req_q.pc;
    assign rsp.epoch = req_q.epoch;
    assign rsp.instr = data_mem[idx];

    // single word lines, so the refill address is the word itself
    assign mem_req.addr = {req_q.pc[addr_w-1:byte_off_w], {byte_off_w{1'b0}}};

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            idle:
            begin
                if (accept)
                    state_d = compare;
            end
            compare:
            begin
                // a hit waits here for the consumer
                if (!hit)
                    state_d = refill_req;
                else if (rsp_ready)
                    state_d = idle;
            end
            refill_req:
            begin
                if (mem_req_ready)
                    state_d = refill_wait;
            end
            refill_wait:
            begin
                // retry lookup once the line is written
                if (mem_rsp_valid)
                    state_d = compare;
            end
            default:
            begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state_q <= idle;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_q <= req;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_valid <= '0;
        end
        else if (refill_done)
        begin
            line_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_done)
        begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= mem_rsp_data;
        end
    end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         redirect_valid,
    input  logic [fetch_pkg::addr_w-1:0] redirect_pc,

    output logic                         req_valid,
    input  logic                         req_ready,
    output fetch_pkg::fetch_req_t        req,

    input  logic                         rsp_valid,
    output logic                         rsp_ready,
    input  fetch_pkg::fetch_rsp_t        rsp,

    output logic                         out_valid,
    input  logic                         out_ready,
    output fetch_pkg::fetch_bundle_t     out_bundle
);

    import fetch_pkg::*;

    localparam logic [addr_w-1:0] pc_step = addr_w'(1 << byte_off_w);

    logic [addr_w-1:0] pc_q;
    logic              running_q;
    logic              epoch_q;
    logic              held_q;
    logic              keep;

    assign req_valid = running_q;
    assign req.pc    = pc_q;
    assign req.epoch = epoch_q;

    // a bundle already on offer stays valid even if a redirect flips the epoch
    assign keep = (rsp.epoch == epoch_q) || held_q;

    assign out_valid        = rsp_valid && keep;
    assign out_bundle.pc    = rsp.pc;
    assign out_bundle.instr = rsp.instr;

    // stale responses are drained without output
    assign rsp_ready = keep ? out_ready : 1'b1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running_q <= 1'b0;
            epoch_q   <= 1'b0;
            held_q    <= 1'b0;
        end
        else
        begin
            held_q <= out_valid && !out_ready;
            if (redirect_valid)
            begin
                running_q <= 1'b1;
                epoch_q   <= ~epoch_q;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (redirect_valid)
            pc_q <= {redirect_pc[addr_w-1:byte_off_w], {byte_off_w{1'b0}}};
        else if (req_valid && req_ready)
            pc_q <= pc_q + pc_step;
    end

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int LINES = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     redirect_valid,
    input  logic [31:0]              redirect_pc,

    output logic                     out_valid,
    input  logic                     out_ready,
    output fetch_pkg::fetch_bundle_t out_bundle,

    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output fetch_pkg::mem_req_t      mem_req,

    input  logic                     mem_rsp_valid,
    output logic                     mem_rsp_ready,
    input  logic [31:0]              mem_rsp_data
);

    import fetch_pkg::*;

    // fetch unit to request skid
    logic       fu_req_valid;
    logic       fu_req_ready;
    fetch_req_t fu_req;

    // request skid to cache
    logic       c_req_valid;
    logic       c_req_ready;
    fetch_req_t c_req;

    // cache to response skid
    logic       c_rsp_valid;
    logic       c_rsp_ready;
    fetch_rsp_t c_rsp;

    // response skid to fetch unit
    logic       fu_rsp_valid;
    logic       fu_rsp_ready;
    fetch_rsp_t fu_rsp;

    fetch_unit u_fetch (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .req_valid      (fu_req_valid),
        .req_ready      (fu_req_ready),
        .req            (fu_req),
        .rsp_valid      (fu_rsp_valid),
        .rsp_ready      (fu_rsp_ready),
        .rsp            (fu_rsp),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_bundle     (out_bundle)
    );

    stream_skid #(.payload_t(fetch_req_t)) u_req_skid (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fu_req_valid),
        .in_data   (fu_req),
        .in_ready  (fu_req_ready),
        .out_valid (c_req_valid),
        .out_data  (c_req),
        .out_ready (c_req_ready)
    );

    i_cache #(.LINES(LINES)) u_cache (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (c_req_valid),
        .req_ready     (c_req_ready),
        .req           (c_req),
        .rsp_valid     (c_rsp_valid),
        .rsp_ready     (c_rsp_ready),
        .rsp           (c_rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data)
    );

    stream_skid #(.payload_t(fetch_rsp_t)) u_rsp_skid (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (c_rsp_valid),
        .in_data   (c_rsp),
        .in_ready  (c_rsp_ready),
        .out_valid (fu_rsp_valid),
        .out_data  (fu_rsp),
        .out_ready (fu_rsp_ready)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic rst_req,
    output logic clk,
    output logic rst
);

    int boot_cycles;

    initial
    begin
        clk         = 1'b0;
        boot_cycles = 0;
        rst        <= 1'b1;
    end

    // 8 ns period
    always #4 clk = ~clk;

    // power-on reset for five cycles, extended by rst_req
    always @(negedge clk)
    begin
        rst <= (boot_cycles < 5) || rst_req;
        if (boot_cycles < 5)
            boot_cycles = boot_cycles + 1;
    end

endmodule

//--- bench/fetch_top_checker.sv
`timescale 1ns/1ps

module fetch_top_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     out_valid,
    input logic                     out_ready,
    input fetch_pkg::fetch_bundle_t out_bundle,
    input logic                     mem_req_valid,
    input logic                     mem_req_ready,
    input fetch_pkg::mem_req_t      mem_req,
    input fetch_pkg::cache_state_t  cache_state
);

    import fetch_pkg::*;

    int fail_count = 0;

    // stalled bundle stays on offer unchanged
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bundle))
    else
    begin
        fail_count++;
        $error("out bundle dropped or changed while stalled");
    end

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else
    begin
        fail_count++;
        $error("memory request dropped or changed while stalled");
    end

    // reset clears the valids and parks the cache
    assert property (@(posedge clk)
        rst |=> !out_valid && !mem_req_valid && cache_state == idle)
    else
    begin
        fail_count++;
        $error("valid output or cache state not cleared after reset");
    end

endmodule

bind fetch_top fetch_top_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_bundle    (out_bundle),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .cache_state   (u_cache.state_q)
);

//--- bench/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam int          lines      = 16;
    localparam int          wait_limit = 2000;
    localparam logic [31:0] instr_key  = 32'h1234_0000;

    logic          clk, rst, rst_req;
    logic          redirect_valid, out_valid, out_ready;
    logic [31:0]   redirect_pc, mem_rsp_data;
    fetch_bundle_t out_bundle;
    logic          mem_req_valid, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    mem_req_t      mem_req;

    // memory model and lfsr state
    logic [31:0]   lfsr_q, pend_addr, last_out_pc;
    logic          ready_gate, pend, req_taken, rsp_taken;
    int            pend_delay;
    logic [31:0]   mem_log [$];

    int test_errors, tests_passed, tests_failed, assert_fails;

    tb_clock u_clock (
        .rst_req (rst_req),
        .clk     (clk),
        .rst     (rst)
    );

    fetch_top #(.LINES(lines)) u_dut (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_bundle     (out_bundle),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .mem_rsp_data   (mem_rsp_data)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [3:0] draw_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int count_in_window(input int from, input logic [31:0] lo,
                                           input logic [31:0] hi);
        int n;
        n = 0;
        for (int i = from; i < mem_log.size(); i++)
            if (mem_log[i] >= lo && mem_log[i] < hi)
                n++;
        return n;
    endfunction

    task automatic report_mismatch(input string msg);
        test_errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // memory model, one refill outstanding at a time
    always @(negedge clk)
    begin
        if (rst)
        begin
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
            pend          = 1'b0;
            req_taken     = 1'b0;
            rsp_taken     = 1'b0;
        end
        else
        begin
            if (rsp_taken)
                mem_rsp_valid = 1'b0;
            if (req_taken)
            begin
                pend       = 1'b1;
                pend_delay = 1 + int'(draw_bits(2));
            end
            if (pend)
            begin
                pend_delay--;
                if (pend_delay == 0)
                begin
                    pend          = 1'b0;
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = pend_addr ^ instr_key;
                end
            end
            mem_req_ready = !pend && !mem_rsp_valid && (draw_bits(1) != 0);
            req_taken     = mem_req_valid && mem_req_ready;
            rsp_taken     = mem_rsp_valid && mem_rsp_ready;
            if (req_taken)
            begin
                pend_addr = mem_req.addr;
                mem_log.push_back(mem_req.addr);
            end
            ready_gate <= (draw_bits(2) != 0);
        end
    end

    // called at a falling edge; redirects, then takes count bundles from start
    task automatic take_bundles(input logic [31:0] start, input int count,
                                input bit throttle, input bit stall_end);
        logic [31:0] expect_pc;
        int          got, old_seen, idle;
        bit          started;
        expect_pc      = start;
        got            = 0;
        old_seen       = 0;
        idle           = 0;
        started        = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc    = start;
        while (got < count)
        begin
            out_ready = throttle ? ready_gate : 1'b1;
            if (out_valid && out_ready)
            begin
                idle = 0;
                if (!started && out_bundle.pc != start)
                begin
                    // tail of the previous stream
                    old_seen++;
                    if (out_bundle.pc != last_out_pc + 32'd4 || old_seen > 2)
                        report_mismatch($sformatf("stray pc %h before %h", out_bundle.pc, start));
                end
                else
                begin
                    started = 1'b1;
                    if (out_bundle.pc != expect_pc)
                        report_mismatch($sformatf("pc %h, expected %h", out_bundle.pc, expect_pc));
                    expect_pc = expect_pc + 32'd4;
                    got++;
                end
                if (out_bundle.instr != (out_bundle.pc ^ instr_key))
                    report_mismatch($sformatf("pc %h instr %h", out_bundle.pc, out_bundle.instr));
                last_out_pc = out_bundle.pc;
            end
            else
            begin
                idle++;
                if (idle > wait_limit)
                    abort_on_timeout("no bundle arrived on the out stream");
            end
            @(negedge clk);
            redirect_valid = 1'b0;
        end
        if (stall_end)
            out_ready = 1'b0;
    endtask

    task automatic expect_requests(input int mark, input logic [31:0] lo, input int want);
        int n;
        n = count_in_window(mark, lo, lo + 32'h20);
        if (n != want)
            report_mismatch($sformatf("%0d memory requests at %h, expected %0d", n, lo, want));
    endtask

    task automatic test_sequential();
        take_bundles(32'h100, 8, 1'b0, 1'b1);
        expect_requests(0, 32'h100, 8);
        close_test("sequential fetch");
    endtask

    task automatic test_hit_reuse();
        int mark;
        mark = mem_log.size();
        take_bundles(32'h100, 8, 1'b0, 1'b1);
        expect_requests(mark, 32'h100, 0);
        close_test("hit reuse");
    endtask

    task automatic test_conflict();
        int mark;
        mark = mem_log.size();
        take_bundles(32'h100 + lines * 4, 8, 1'b0, 1'b1);
        expect_requests(mark, 32'h100 + lines * 4, 8);
        mark = mem_log.size();
        take_bundles(32'h100, 8, 1'b0, 1'b1);
        expect_requests(mark, 32'h100, 8);
        close_test("conflict miss");
    endtask

    task automatic test_backpressure();
        take_bundles(32'h200, 20, 1'b1, 1'b1);
        close_test("back-pressure");
    endtask

    task automatic test_redirect();
        take_bundles(32'h300, 6, 1'b0, 1'b0);
        take_bundles(32'h400, 8, 1'b0, 1'b1);
        close_test("redirect mid-stream");
    endtask

    task automatic test_reset();
        int mark, n;
        take_bundles(32'h100, 8, 1'b0, 1'b0);
        rst_req  <= 1'b1;
        out_ready = 1'b0;
        n         = 0;
        while (!rst)
        begin
            @(negedge clk);
            n++;
            if (n > wait_limit)
                abort_on_timeout("reset was never asserted");
        end
        if (out_valid || mem_req_valid)
            report_mismatch("valid output high in reset");
        repeat (3) @(negedge clk);
        rst_req <= 1'b0;
        n = 0;
        while (rst)
        begin
            @(negedge clk);
            n++;
            if (n > wait_limit)
                abort_on_timeout("reset was never released");
        end
        if (out_valid || mem_req_valid)
            report_mismatch("valid output high after reset");
        mark = mem_log.size();
        take_bundles(32'h100, 8, 1'b0, 1'b1);
        expect_requests(mark, 32'h100, 8);
        close_test("reset");
    endtask

    initial
    begin
        int n;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        out_ready      = 1'b0;
        mem_req_ready  = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        rst_req       <= 1'b0;
        ready_gate    <= 1'b1;
        lfsr_q         = 32'h5e6f;
        pend           = 1'b0;
        pend_delay     = 0;
        req_taken      = 1'b0;
        rsp_taken      = 1'b0;
        last_out_pc    = '1;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        n              = 0;
        @(negedge clk);
        while (rst)
        begin
            @(negedge clk);
            n++;
            if (n > wait_limit)
                abort_on_timeout("power-on reset was never released");
        end
        test_sequential();
        test_hit_reuse();
        test_conflict();
        test_backpressure();
        test_redirect();
        test_reset();
        repeat (2) @(negedge clk);
        assert_fails = u_dut.u_checker.fail_count;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- fetch_top.f
source/fetch_pkg.sv
source/stream_skid.sv
source/i_cache.sv
source/fetch_unit.sv
source/fetch_top.sv
bench/tb_clock.sv
bench/fetch_top_checker.sv
bench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - source/fetch_pkg.sv
  - source/stream_skid.sv
  - source/i_cache.sv
  - source/fetch_unit.sv
  - source/fetch_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/fetch_top_checker.sv
      - bench/fetch_tb.sv
